// ==== verilog/mips_decode_pkg.sv ====
package mips_decode_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [2:0]  alu_op_t;
	typedef logic [3:0]  alu_code_t;

	//////////////////////////////
	// ALU operation class, from main decoder to ALU controller
	localparam alu_op_t ALUOP_RTYPE = 3'd0;   // Look at funct
	localparam alu_op_t ALUOP_ADD   = 3'd1;
	localparam alu_op_t ALUOP_AND   = 3'd2;
	localparam alu_op_t ALUOP_OR    = 3'd3;
	localparam alu_op_t ALUOP_XOR   = 3'd4;
	localparam alu_op_t ALUOP_SLT   = 3'd5;
	localparam alu_op_t ALUOP_SUB   = 3'd6;   // Branch compare
	localparam alu_op_t ALUOP_LUI   = 3'd7;

	// ALU operation codes seen by execute
	localparam alu_code_t ALU_ADD  = 4'd0;   // Also the idle code
	localparam alu_code_t ALU_ADDU = 4'd1;
	localparam alu_code_t ALU_SUB  = 4'd2;
	localparam alu_code_t ALU_SUBU = 4'd3;
	localparam alu_code_t ALU_AND  = 4'd4;
	localparam alu_code_t ALU_OR   = 4'd5;
	localparam alu_code_t ALU_XOR  = 4'd6;
	localparam alu_code_t ALU_NOR  = 4'd7;
	localparam alu_code_t ALU_SLT  = 4'd8;
	localparam alu_code_t ALU_SLTU = 4'd9;
	localparam alu_code_t ALU_SLL  = 4'd10;
	localparam alu_code_t ALU_SRL  = 4'd11;
	localparam alu_code_t ALU_SRA  = 4'd12;
	localparam alu_code_t ALU_SLLV = 4'd13;
	localparam alu_code_t ALU_SRLV = 4'd14;
	localparam alu_code_t ALU_LUI  = 4'd15;

	//////////////////////////////
	// Opcodes
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_J     = 6'b000010;
	localparam opcode_t OP_JAL   = 6'b000011;
	localparam opcode_t OP_BEQ   = 6'b000100;
	localparam opcode_t OP_BNE   = 6'b000101;
	localparam opcode_t OP_ADDI  = 6'b001000;
	localparam opcode_t OP_SLTI  = 6'b001010;
	localparam opcode_t OP_ANDI  = 6'b001100;
	localparam opcode_t OP_ORI   = 6'b001101;
	localparam opcode_t OP_XORI  = 6'b001110;
	localparam opcode_t OP_LUI   = 6'b001111;
	localparam opcode_t OP_LB    = 6'b100000;
	localparam opcode_t OP_LH    = 6'b100001;
	localparam opcode_t OP_LW    = 6'b100011;
	localparam opcode_t OP_LBU   = 6'b100100;
	localparam opcode_t OP_LHU   = 6'b100101;
	localparam opcode_t OP_SB    = 6'b101000;
	localparam opcode_t OP_SH    = 6'b101001;
	localparam opcode_t OP_SW    = 6'b101011;

	// R-type funct values
	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_SRA  = 6'b000011;
	localparam funct_t FN_SLLV = 6'b000100;
	localparam funct_t FN_SRLV = 6'b000110;
	localparam funct_t FN_JR   = 6'b001000;
	localparam funct_t FN_JALR = 6'b001001;
	localparam funct_t FN_ADD  = 6'b100000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUB  = 6'b100010;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_XOR  = 6'b100110;
	localparam funct_t FN_NOR  = 6'b100111;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

	//////////////////////////////
	// Control groups, bit order matches the execute/memory/write-back buses
	typedef struct packed {
		logic      reg_dst;
		logic      alu_src_shamt;
		logic      alu_src_imm;
		logic      jump;
		logic      jump_reg;
		alu_code_t alu_code;
	} ex_ctrl_t;

	typedef struct packed {
		logic store_byte;
		logic store_half;
		logic load_byte;
		logic load_half;
		logic load_unsigned;
		logic branch;
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ctrl_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     pc_plus4;
		word_t     rs_data;
		word_t     rt_data;
		word_t     imm;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt;
	} id_ex_t;

endpackage

// ==== verilog/alu_control.sv ====
`timescale 1ns/1ps

module alu_control (
	input  mips_decode_pkg::alu_op_t   alu_op,
	input  mips_decode_pkg::funct_t    funct,
	output mips_decode_pkg::alu_code_t alu_code
);
	import mips_decode_pkg::*;

	always_comb
	begin
		alu_code = ALU_ADD;
		case (alu_op)
			ALUOP_RTYPE:
			begin
				case (funct)
					FN_ADD:  alu_code = ALU_ADD;
					FN_ADDU: alu_code = ALU_ADDU;
					FN_SUB:  alu_code = ALU_SUB;
					FN_SUBU: alu_code = ALU_SUBU;
					FN_AND:  alu_code = ALU_AND;
					FN_OR:   alu_code = ALU_OR;
					FN_XOR:  alu_code = ALU_XOR;
					FN_NOR:  alu_code = ALU_NOR;
					FN_SLT:  alu_code = ALU_SLT;
					FN_SLTU: alu_code = ALU_SLTU;
					FN_SLL:  alu_code = ALU_SLL;
					FN_SRL:  alu_code = ALU_SRL;
					FN_SRA:  alu_code = ALU_SRA;
					FN_SLLV: alu_code = ALU_SLLV;
					FN_SRLV: alu_code = ALU_SRLV;
					FN_JR, FN_JALR: alu_code = ALU_ADD;   // Link address add
					default: alu_code = ALU_ADD;
				endcase
			end
			ALUOP_ADD: alu_code = ALU_ADD;
			ALUOP_AND: alu_code = ALU_AND;
			ALUOP_OR:  alu_code = ALU_OR;
			ALUOP_XOR: alu_code = ALU_XOR;
			ALUOP_SLT: alu_code = ALU_SLT;
			ALUOP_SUB: alu_code = ALU_SUB;
			ALUOP_LUI: alu_code = ALU_LUI;
			default:   alu_code = ALU_ADD;
		endcase
	end

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
	input  mips_decode_pkg::word_t instr,
	output mips_decode_pkg::ctrl_t ctrl,
	output mips_decode_pkg::word_t imm
);
	import mips_decode_pkg::*;

	opcode_t   opcode;
	funct_t    funct;
	alu_op_t   alu_op;
	alu_code_t alu_code;
	ctrl_t     dec;        // Main decode, ALU code merged in later
	logic      zero_ext;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	alu_control u_alu_control (
		.alu_op   (alu_op),
		.funct    (funct),
		.alu_code (alu_code)
	);

	//////////////////////////////
	// Main decoder
	always_comb
	begin
		dec      = '0;
		alu_op   = ALUOP_ADD;   // Gives ALU_ADD, so unknown opcodes stay all zero
		zero_ext = 1'b0;
		case (opcode)
			OP_RTYPE:
			begin
				alu_op = ALUOP_RTYPE;
				dec.wb.reg_write = 1'b1;
				case (funct)
					FN_SLL, FN_SRL, FN_SRA:
					begin
						dec.ex.reg_dst       = 1'b1;
						dec.ex.alu_src_shamt = 1'b1;
					end
					FN_JR, FN_JALR:
						dec.ex.jump_reg = 1'b1;   // Register jumps
					default:
						dec.ex.reg_dst = 1'b1;
				endcase
			end

			// Loads
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
			begin
				dec.ex.alu_src_imm    = 1'b1;
				dec.mem.mem_read      = 1'b1;
				dec.wb.reg_write      = 1'b1;
				dec.wb.mem_to_reg     = 1'b1;
				dec.mem.load_byte     = (opcode == OP_LB) || (opcode == OP_LBU);
				dec.mem.load_half     = (opcode == OP_LH) || (opcode == OP_LHU);
				dec.mem.load_unsigned = (opcode == OP_LBU) || (opcode == OP_LHU);
			end

			// Stores
			OP_SB, OP_SH, OP_SW:
			begin
				dec.ex.alu_src_imm = 1'b1;
				dec.mem.mem_write  = 1'b1;
				dec.mem.store_byte = (opcode == OP_SB);
				dec.mem.store_half = (opcode == OP_SH);
			end

			OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
			begin
				dec.ex.alu_src_imm = 1'b1;
				dec.wb.reg_write   = 1'b1;
				case (opcode)
					OP_SLTI: alu_op = ALUOP_SLT;
					OP_ANDI:
					begin
						alu_op   = ALUOP_AND;
						zero_ext = 1'b1;
					end
					OP_ORI:
					begin
						alu_op   = ALUOP_OR;
						zero_ext = 1'b1;
					end
					OP_XORI:
					begin
						alu_op   = ALUOP_XOR;
						zero_ext = 1'b1;
					end
					OP_LUI:  alu_op = ALUOP_LUI;
					default: alu_op = ALUOP_ADD;   // ADDI
				endcase
			end

			OP_BEQ, OP_BNE:
			begin
				dec.mem.branch = 1'b1;
				alu_op         = ALUOP_SUB;   // Compare by subtraction
			end
			OP_J:
				dec.ex.jump = 1'b1;
			OP_JAL:
			begin
				dec.ex.jump      = 1'b1;
				dec.wb.reg_write = 1'b1;   // Link register
			end
			default:
				dec = '0;
		endcase
	end

	always_comb
	begin
		ctrl             = dec;
		ctrl.ex.alu_code = alu_code;
	end

	assign imm = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic                      clk,
	input  logic                      reset,
	input  mips_decode_pkg::reg_addr_t rs_addr,
	input  mips_decode_pkg::reg_addr_t rt_addr,
	output mips_decode_pkg::word_t     rs_data,
	output mips_decode_pkg::word_t     rt_data,
	input  logic                      we,
	input  mips_decode_pkg::reg_addr_t wr_addr,
	input  mips_decode_pkg::word_t     wr_data
);
	import mips_decode_pkg::*;

	word_t regs [32];
	logic  wr_en;

	assign wr_en = we && (wr_addr != '0);   // r0 is read-only

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
			regs[wr_addr] <= wr_data;
	end

	// Read ports with write-back bypass
	always_comb
	begin
		if (rs_addr == '0)
			rs_data = '0;
		else if (wr_en && (wr_addr == rs_addr))
			rs_data = wr_data;
		else
			rs_data = regs[rs_addr];

		if (rt_addr == '0)
			rt_data = '0;
		else if (wr_en && (wr_addr == rt_addr))
			rt_data = wr_data;
		else
			rt_data = regs[rt_addr];
	end

endmodule

// ==== verilog/id_ex_register.sv ====
`timescale 1ns/1ps

module id_ex_register (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    stall,
	input  logic                    flush,
	input  mips_decode_pkg::id_ex_t d,
	output mips_decode_pkg::id_ex_t q
);

	//////////////////////////////
	// Reset beats flush, flush beats stall
	always_ff @(posedge clk)
	begin
		if (reset)
			q <= '0;
		else if (flush)
		begin
			// Bubble, only the control bundle has to be cleared
			q      <= d;
			q.ctrl <= '0;
		end
		else if (!stall)
			q <= d;
	end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  mips_decode_pkg::word_t     instr,
	input  mips_decode_pkg::word_t     pc_plus4,
	input  logic                      stall,
	input  logic                      flush,
	input  logic                      wb_we,
	input  mips_decode_pkg::reg_addr_t wb_addr,
	input  mips_decode_pkg::word_t     wb_data,
	output mips_decode_pkg::id_ex_t    id_ex
);
	import mips_decode_pkg::*;

	ctrl_t     ctrl;
	word_t     imm;
	word_t     rs_data;
	word_t     rt_data;
	reg_addr_t rs;
	reg_addr_t rt;
	id_ex_t    id_ex_d;

	// Register fields of the instruction word
	assign rs = instr[25:21];
	assign rt = instr[20:16];

	control_unit u_control_unit (
		.instr (instr),
		.ctrl  (ctrl),
		.imm   (imm)
	);

	register_file u_register_file (
		.clk     (clk),
		.reset   (reset),
		.rs_addr (rs),
		.rt_addr (rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.we      (wb_we),
		.wr_addr (wb_addr),
		.wr_data (wb_data)
	);

	always_comb
	begin
		id_ex_d.ctrl     = ctrl;
		id_ex_d.pc_plus4 = pc_plus4;
		id_ex_d.rs_data  = rs_data;
		id_ex_d.rt_data  = rt_data;
		id_ex_d.imm      = imm;
		id_ex_d.rs       = rs;
		id_ex_d.rt       = rt;
		id_ex_d.rd       = instr[15:11];
		id_ex_d.shamt    = instr[10:6];   // Shift amount
	end

	id_ex_register u_id_ex_register (
		.clk   (clk),
		.reset (reset),
		.stall (stall),
		.flush (flush),
		.d     (id_ex_d),
		.q     (id_ex)
	);

endmodule

// ==== tests/decode_stage_sva.sv ====
`timescale 1ns/1ps

module decode_stage_sva (
	input logic                    clk,
	input logic                    reset,
	input logic                    flush,
	input mips_decode_pkg::id_ex_t id_ex
);
	import mips_decode_pkg::*;

	ctrl_t c;

	assign c = id_ex.ctrl;

	// Load and store never at once
	assert property (@(posedge clk) disable iff (reset) !(c.mem.mem_read && c.mem.mem_write))
		else $error("mem_read and mem_write both set");

	assert property (@(posedge clk) disable iff (reset) c.wb.mem_to_reg |-> c.wb.reg_write)
		else $error("mem_to_reg set without reg_write");

	// One control transfer kind at most
	assert property (@(posedge clk) disable iff (reset)
		$onehot0({c.mem.branch, c.ex.jump, c.ex.jump_reg}))
		else $error("branch, jump and jump_reg overlap");

	assert property (@(posedge clk) (reset || flush) |=> (c == '0))
		else $error("control bundle not cleared after reset or flush");

endmodule

bind decode_stage decode_stage_sva u_decode_stage_sva (
	.clk   (clk),
	.reset (reset),
	.flush (flush),
	.id_ex (id_ex)
);

// ==== tests/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb;
	import mips_decode_pkg::*;

	localparam int RESET_CYCLES = 16;

	// Control group bit patterns
	localparam logic [4:0] EX_NONE  = 5'b00000;
	localparam logic [4:0] EX_RD    = 5'b10000;
	localparam logic [4:0] EX_SHIFT = 5'b11000;
	localparam logic [4:0] EX_IMM   = 5'b00100;
	localparam logic [4:0] EX_JUMP  = 5'b00010;
	localparam logic [4:0] EX_JREG  = 5'b00001;
	localparam logic [1:0] WB_NONE  = 2'b00;
	localparam logic [1:0] WB_REG   = 2'b10;
	localparam logic [1:0] WB_LOAD  = 2'b11;

	typedef struct packed {
		word_t      instr;
		word_t      pc_plus4;
		logic       stall;
		logic       flush;
		logic       wb_we;
		reg_addr_t  wb_addr;
		word_t      wb_data;
		logic       check_data;   // Low for bubbles
		ctrl_t      exp_ctrl;
		word_t      exp_pc;
		word_t      exp_rs_data;
		word_t      exp_rt_data;
		word_t      exp_imm;
		reg_addr_t  exp_rs;
		reg_addr_t  exp_rt;
		reg_addr_t  exp_rd;
		logic [4:0] exp_shamt;
	} row_t;

	logic      clk;
	logic      reset;
	word_t     instr;
	word_t     pc_plus4;
	logic      stall;
	logic      flush;
	logic      wb_we;
	reg_addr_t wb_addr;
	word_t     wb_data;
	id_ex_t    id_ex;

	row_t  rows [$];
	row_t  last_exp;   // What id_ex holds so far
	word_t model [32];
	int    cycles;
	int    cycle_limit;

	decode_stage UUT (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.pc_plus4 (pc_plus4),
		.stall    (stall),
		.flush    (flush),
		.wb_we    (wb_we),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data),
		.id_ex    (id_ex)
	);

	always #20 clk = ~clk;

	//////////////////////////////
	// Failure reporting and compare tasks
	task automatic fail_run();
		$display("Verification failed");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_ctrl(input string what, input ctrl_t got, input ctrl_t exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			fail_run();
		end
	endtask

	//////////////////////////////
	// Instruction encoders and expected control
	function automatic word_t enc_r(input funct_t fn, input reg_addr_t rs, input reg_addr_t rt,
			input logic [4:0] sh);
		return {OP_RTYPE, rs, rt, rs + 5'd10, sh, fn};   // rd follows rs
	endfunction

	function automatic word_t enc_i(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic ctrl_t ctrl_bits(input logic [4:0] ex, input alu_code_t code,
			input logic [7:0] mem, input logic [1:0] wb);
		return {ex, code, mem, wb};
	endfunction

	function automatic ctrl_t r_ctrl(input alu_code_t code);
		return ctrl_bits(EX_RD, code, 8'h00, WB_REG);
	endfunction

	function automatic word_t read_model(input reg_addr_t a, input logic wr, input reg_addr_t wa,
			input word_t wd);
		if (a == 5'd0)
			return '0;
		if (wr && (wa == a))
			return wd;   // Same-cycle write
		return model[a];
	endfunction

	task automatic add_row(input word_t ins, input ctrl_t c, input logic stl, input logic fl,
			input logic we, input reg_addr_t wa, input word_t wd);
		row_t  r;
		logic  wr;
		word_t pc;
		r  = '0;
		pc = 32'h0040_0004 + 4 * rows.size();
		wr = we && (wa != 5'd0);
		if (stl && !fl)
			r = last_exp;
		else
		begin
			r.check_data  = !fl;
			r.exp_ctrl    = fl ? '0 : c;
			r.exp_pc      = pc;
			r.exp_rs      = ins[25:21];
			r.exp_rt      = ins[20:16];
			r.exp_rd      = ins[15:11];
			r.exp_shamt   = ins[10:6];
			r.exp_rs_data = read_model(ins[25:21], wr, wa, wd);
			r.exp_rt_data = read_model(ins[20:16], wr, wa, wd);
			if (ins[31:26] inside {OP_ANDI, OP_ORI, OP_XORI})
				r.exp_imm = {16'h0000, ins[15:0]};
			else
				r.exp_imm = {{16{ins[15]}}, ins[15:0]};
		end
		r.instr    = ins;
		r.pc_plus4 = pc;
		r.stall    = stl;
		r.flush    = fl;
		r.wb_we    = we;
		r.wb_addr  = wa;
		r.wb_data  = wd;
		last_exp   = r;
		if (wr)
			model[wa] = wd;
		rows.push_back(r);
	endtask

	task automatic decode_row(input word_t ins, input ctrl_t c);
		add_row(ins, c, 1'b0, 1'b0, 1'b0, 5'd0, '0);
	endtask

	//////////////////////////////
	// Stimulus table
	task automatic build_table();
		word_t v;
		// Fill r1..r7 while rs reads through the bypass
		for (int i = 1; i < 8; i++)
		begin
			v = $urandom();
			add_row(enc_r(FN_ADDU, 5'(i), 5'(i - 1), 5'd0), r_ctrl(ALU_ADDU),
				1'b0, 1'b0, 1'b1, 5'(i), v);
		end
		add_row(enc_r(FN_ADD, 5'd0, 5'd0, 5'd0), r_ctrl(ALU_ADD),
			1'b0, 1'b0, 1'b1, 5'd0, $urandom());   // r0 ignores writes
		decode_row(enc_r(FN_ADD, 5'd1, 5'd0, 5'd0), r_ctrl(ALU_ADD));
		decode_row(enc_r(FN_SUB, 5'd3, 5'd4, 5'd0), r_ctrl(ALU_SUB));
		decode_row(enc_r(FN_SUBU, 5'd5, 5'd6, 5'd0), r_ctrl(ALU_SUBU));
		decode_row(enc_r(FN_AND, 5'd7, 5'd1, 5'd0), r_ctrl(ALU_AND));
		decode_row(enc_r(FN_OR, 5'd2, 5'd3, 5'd0), r_ctrl(ALU_OR));
		decode_row(enc_r(FN_XOR, 5'd4, 5'd5, 5'd0), r_ctrl(ALU_XOR));
		decode_row(enc_r(FN_NOR, 5'd6, 5'd7, 5'd0), r_ctrl(ALU_NOR));
		decode_row(enc_r(FN_SLT, 5'd1, 5'd3, 5'd0), r_ctrl(ALU_SLT));
		decode_row(enc_r(FN_SLTU, 5'd2, 5'd4, 5'd0), r_ctrl(ALU_SLTU));
		decode_row(enc_r(FN_SLLV, 5'd5, 5'd1, 5'd0), r_ctrl(ALU_SLLV));
		decode_row(enc_r(FN_SRLV, 5'd6, 5'd2, 5'd0), r_ctrl(ALU_SRLV));
		decode_row(enc_r(FN_SLL, 5'd0, 5'd3, 5'd7), ctrl_bits(EX_SHIFT, ALU_SLL, 8'h00, WB_REG));
		decode_row(enc_r(FN_SRL, 5'd0, 5'd4, 5'd31), ctrl_bits(EX_SHIFT, ALU_SRL, 8'h00, WB_REG));
		decode_row(enc_r(FN_SRA, 5'd0, 5'd5, 5'd16), ctrl_bits(EX_SHIFT, ALU_SRA, 8'h00, WB_REG));
		decode_row(enc_r(FN_JR, 5'd7, 5'd0, 5'd0), ctrl_bits(EX_JREG, ALU_ADD, 8'h00, WB_REG));
		decode_row(enc_r(FN_JALR, 5'd6, 5'd0, 5'd0), ctrl_bits(EX_JREG, ALU_ADD, 8'h00, WB_REG));
		// Loads and stores with mem bits sb sh lb lh lu br rd wr
		decode_row(enc_i(OP_LB, 5'd1, 5'd8, 16'hfffc), ctrl_bits(EX_IMM, ALU_ADD, 8'h22, WB_LOAD));
		decode_row(enc_i(OP_LBU, 5'd2, 5'd8, 16'h0003), ctrl_bits(EX_IMM, ALU_ADD, 8'h2a, WB_LOAD));
		decode_row(enc_i(OP_LH, 5'd3, 5'd8, 16'h8000), ctrl_bits(EX_IMM, ALU_ADD, 8'h12, WB_LOAD));
		decode_row(enc_i(OP_LHU, 5'd4, 5'd8, 16'h0002), ctrl_bits(EX_IMM, ALU_ADD, 8'h1a, WB_LOAD));
		decode_row(enc_i(OP_LW, 5'd5, 5'd8, 16'h0010), ctrl_bits(EX_IMM, ALU_ADD, 8'h02, WB_LOAD));
		decode_row(enc_i(OP_SB, 5'd6, 5'd1, 16'h0001), ctrl_bits(EX_IMM, ALU_ADD, 8'h81, WB_NONE));
		decode_row(enc_i(OP_SH, 5'd7, 5'd2, 16'hfffe), ctrl_bits(EX_IMM, ALU_ADD, 8'h41, WB_NONE));
		decode_row(enc_i(OP_SW, 5'd1, 5'd3, 16'h0020), ctrl_bits(EX_IMM, ALU_ADD, 8'h01, WB_NONE));
		// Negative ADDI sign-extends and ORI zero-extends
		decode_row(enc_i(OP_ADDI, 5'd2, 5'd9, 16'hfff0), ctrl_bits(EX_IMM, ALU_ADD, 8'h00, WB_REG));
		decode_row(enc_i(OP_SLTI, 5'd3, 5'd9, 16'h8001), ctrl_bits(EX_IMM, ALU_SLT, 8'h00, WB_REG));
		decode_row(enc_i(OP_ANDI, 5'd4, 5'd9, 16'hff00), ctrl_bits(EX_IMM, ALU_AND, 8'h00, WB_REG));
		decode_row(enc_i(OP_ORI, 5'd5, 5'd9, 16'h8001), ctrl_bits(EX_IMM, ALU_OR, 8'h00, WB_REG));
		decode_row(enc_i(OP_XORI, 5'd6, 5'd9, 16'hf0f0), ctrl_bits(EX_IMM, ALU_XOR, 8'h00, WB_REG));
		decode_row(enc_i(OP_LUI, 5'd0, 5'd9, 16'habcd), ctrl_bits(EX_IMM, ALU_LUI, 8'h00, WB_REG));
		// Branches, jumps and an unknown opcode
		decode_row(enc_i(OP_BEQ, 5'd1, 5'd2, 16'h0004), ctrl_bits(EX_NONE, ALU_SUB, 8'h04, WB_NONE));
		decode_row(enc_i(OP_BNE, 5'd3, 5'd4, 16'hfffb), ctrl_bits(EX_NONE, ALU_SUB, 8'h04, WB_NONE));
		decode_row({OP_J, 26'h0100040}, ctrl_bits(EX_JUMP, ALU_ADD, 8'h00, WB_NONE));
		decode_row({OP_JAL, 26'h2a55a5c}, ctrl_bits(EX_JUMP, ALU_ADD, 8'h00, WB_REG));
		decode_row(enc_i(6'b111111, 5'd5, 5'd6, 16'h1234), '0);
		// Stall holds id_ex while r9 is written, then flush bubbles
		decode_row(enc_i(OP_ADDI, 5'd1, 5'd11, 16'h0010), ctrl_bits(EX_IMM, ALU_ADD, 8'h00, WB_REG));
		add_row(enc_i(OP_XORI, 5'd2, 5'd12, 16'h00ff), '0, 1'b1, 1'b0, 1'b1, 5'd9, $urandom());
		decode_row(enc_r(FN_OR, 5'd9, 5'd0, 5'd0), r_ctrl(ALU_OR));
		add_row(enc_i(OP_BEQ, 5'd1, 5'd2, 16'h0004), '0, 1'b0, 1'b1, 1'b0, 5'd0, '0);
		decode_row(enc_r(FN_AND, 5'd9, 5'd1, 5'd0), r_ctrl(ALU_AND));
		add_row(enc_i(OP_LW, 5'd3, 5'd8, 16'h0008), '0, 1'b1, 1'b1, 1'b0, 5'd0, '0);
		add_row(enc_r(FN_SUB, 5'd2, 5'd9, 5'd0), r_ctrl(ALU_SUB),
			1'b0, 1'b0, 1'b1, 5'd9, $urandom());   // rt reads r9 through the bypass
	endtask

	task automatic drive_row(input row_t r);
		instr    = r.instr;
		pc_plus4 = r.pc_plus4;
		stall    = r.stall;
		flush    = r.flush;
		wb_we    = r.wb_we;
		wb_addr  = r.wb_addr;
		wb_data  = r.wb_data;
	endtask

	task automatic check_row(input int n, input row_t r);
		check_ctrl($sformatf("row %0d ctrl", n), id_ex.ctrl, r.exp_ctrl);
		if (r.check_data)
		begin
			check_word($sformatf("row %0d pc_plus4", n), id_ex.pc_plus4, r.exp_pc);
			check_word($sformatf("row %0d rs_data", n), id_ex.rs_data, r.exp_rs_data);
			check_word($sformatf("row %0d rt_data", n), id_ex.rt_data, r.exp_rt_data);
			check_word($sformatf("row %0d imm", n), id_ex.imm, r.exp_imm);
			check_addr($sformatf("row %0d rs", n), id_ex.rs, r.exp_rs);
			check_addr($sformatf("row %0d rt", n), id_ex.rt, r.exp_rt);
			check_addr($sformatf("row %0d rd", n), id_ex.rd, r.exp_rd);
			check_addr($sformatf("row %0d shamt", n), id_ex.shamt, r.exp_shamt);
		end
	endtask

	// Run limit
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("Timeout: test did not finish within %0d cycles", cycle_limit);
			fail_run();
		end
	end

	initial
	begin
		clk      = 1'b0;
		reset    = 1'b1;
		instr    = '0;
		pc_plus4 = '0;
		stall    = 1'b0;
		flush    = 1'b0;
		wb_we    = 1'b0;
		wb_addr  = '0;
		wb_data  = '0;
		cycles   = 0;
		last_exp = '0;
		for (int i = 0; i < 32; i++)
			model[i] = '0;
		void'($urandom(42));
		build_table();
		cycle_limit = RESET_CYCLES + rows.size() + 20;

		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		check_ctrl("reset ctrl", id_ex.ctrl, '0);
		check_word("reset pc_plus4", id_ex.pc_plus4, '0);
		check_word("reset rs_data", id_ex.rs_data, '0);
		check_word("reset rt_data", id_ex.rt_data, '0);
		check_word("reset imm", id_ex.imm, '0);
		check_addr("reset rs", id_ex.rs, '0);
		check_addr("reset rt", id_ex.rt, '0);
		check_addr("reset rd", id_ex.rd, '0);
		check_addr("reset shamt", id_ex.shamt, '0);

		foreach (rows[i])
		begin
			drive_row(rows[i]);
			@(negedge clk);
			check_row(i, rows[i]);
		end
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== mips_decode.f ====
verilog/mips_decode_pkg.sv
verilog/alu_control.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/id_ex_register.sv
verilog/decode_stage.sv
tests/decode_stage_sva.sv
tests/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module decode_stage_tb \
	-f mips_decode.f -o decode_stage_sim \
	&& ./obj_dir/decode_stage_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log 2>/dev/null \
	&& echo "Simulation result: PASS" \
	|| { echo "Simulation result: FAIL"; exit 1; }
